// File: build.f
fxp_pkg.sv
fxp_add.sv
fxp_subtract.sv
fxp_operand_stage.sv
fxp_result_fifo.sv
fxp_saturate_stage.sv
fxp_alu_top.sv
tb_clock_gen.sv
tb_fxp_alu.sv

// File: fxp_add.sv
//--------------------------------------------------
// Ripple carry-chain adder
// n-bit add with carry in and carry out, built as
// an explicit chain of full adders
//--------------------------------------------------
`timescale 1ns/100ps

module fxp_add #(
    // Datapath width in bits
    parameter int n = 16
) (
    input  logic [n-1:0] a,
    input  logic [n-1:0] b,
    input  logic         carry_in,
    output logic [n-1:0] sum,
    output logic         carry_out
);

    // Carry into each bit, plus the final carry
    logic [n:0] carry;

    assign carry[0] = carry_in;

    // One full adder per bit
    for (genvar i = 0; i < n; i++) begin : g_bit
        // Sum bit
        assign sum[i] = a[i] ^ b[i] ^ carry[i];
        // Generate, or propagate the incoming carry
        assign carry[i+1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
    end

    // Carry out of the top bit
    assign carry_out = carry[n];

endmodule

// File: fxp_alu_top.sv
//--------------------------------------------------
// Fixed-point add/subtract unit
// Q8.8 add or subtract with saturation; operand
// stage, result FIFO and saturate stage in a row
//--------------------------------------------------
`timescale 1ns/100ps

module fxp_alu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Operation in
    input  logic                        in_valid,
    input  logic                        op_sub,
    input  logic [fxp_pkg::data_w-1:0]  a,
    input  logic [fxp_pkg::data_w-1:0]  b,
    output logic                        in_ready,
    // Result out
    input  logic                        out_ready,
    output logic                        out_valid,
    output logic [fxp_pkg::data_w-1:0]  result,
    output logic                        saturated
);

    //--------------------------------------------------
    // Internal connections
    //--------------------------------------------------
    // Operand stage to FIFO
    logic                       wr_en;
    logic [fxp_pkg::wide_w-1:0] wr_data;
    // FIFO to saturate stage
    logic                       rd_en;
    logic                       rd_valid;
    logic [fxp_pkg::wide_w-1:0] rd_data;

    // Exact sum or difference, registered
    fxp_operand_stage u_operand (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op_sub   (op_sub),
        .a        (a),
        .b        (b),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    // Buffer, its space flag is the input ready
    fxp_result_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .space    (in_ready)
    );

    // Clamp and hold for the sink
    fxp_saturate_stage u_saturate (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .out_ready (out_ready),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .result    (result),
        .saturated (saturated)
    );

endmodule

// File: fxp_cases.txt
// Columns, all hex: op (0 add, 1 a minus b), a, b, expected result, expected saturated
// Op value ffff marks the end of the cases
// Additions without overflow
0 0100 0200 0300 0
0 0180 ff00 0080 0
0 fe80 ff40 fdc0 0
0 7f00 00ff 7fff 0
0 8000 7fff ffff 0
0 c000 c000 8000 0
0 ff80 0080 0000 0
// Subtractions without overflow
1 0300 0100 0200 0
1 0100 0300 fe00 0
1 ff00 8000 7f00 0
1 0040 ffc0 0080 0
1 8000 8000 0000 0
1 fff0 0010 ffe0 0
1 ffff ffff 0000 0
1 ffff 7fff 8000 0
1 0000 8001 7fff 0
// Positive overflow
0 7fff 0001 7fff 1
0 4000 4000 7fff 1
1 7f00 ff00 7fff 1
1 0000 8000 7fff 1
1 7fff 8000 7fff 1
// Negative overflow
0 8000 ffff 8000 1
0 c000 bfff 8000 1
1 8000 0001 8000 1
1 ff00 7f01 8000 1
0 8000 8000 8000 1
// End marker
ffff 0000 0000 0000 0

// File: fxp_operand_stage.sv
//--------------------------------------------------
// Operand stage
// Takes one operation per in_valid strobe, forms
// the exact wide sum or difference and registers
// it for the result FIFO, one cycle later
//--------------------------------------------------
`timescale 1ns/100ps

module fxp_operand_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic                        op_sub,
    input  logic [fxp_pkg::data_w-1:0]  a,
    input  logic [fxp_pkg::data_w-1:0]  b,
    output logic                        wr_en,
    output logic [fxp_pkg::wide_w-1:0]  wr_data
);

    //--------------------------------------------------
    // Arithmetic
    //--------------------------------------------------
    // Exact a - b
    logic [fxp_pkg::wide_w-1:0] diff;
    // Exact a + b
    logic [fxp_pkg::wide_w-1:0] sum;

    // Subtract path, widens internally
    fxp_subtract #(
        .n        (fxp_pkg::data_w)
    ) u_sub (
        .a        (a),
        .b        (b),
        .diff     (diff)
    );

    // Add path on sign-extended operands, no carry in
    fxp_add #(
        .n        (fxp_pkg::wide_w)
    ) u_add (
        .a        ({a[fxp_pkg::data_w-1], a}),
        .b        ({b[fxp_pkg::data_w-1], b}),
        .carry_in (1'b0),
        .sum      (sum),
        // Guard bit already holds the true sign
        .carry_out()
    );

    //--------------------------------------------------
    // Output register
    //--------------------------------------------------
    // Write strobe, one cycle after in_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_valid;
        end
    end

    // Result word, only loaded with a new operation
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_data <= op_sub ? diff : sum;
        end
    end

endmodule

// File: fxp_pkg.sv
//--------------------------------------------------
// Fixed-point ALU shared definitions
// Q8.8 operand and result widths, widened result
// width, result FIFO sizing and saturation limits
//--------------------------------------------------
package fxp_pkg;

    //--------------------------------------------------
    // Q-format
    //--------------------------------------------------
    // Signed Q8.8 operand and final result width
    localparam int data_w = 16;
    // Fraction bits, same for both operands so add/sub needs no alignment
    localparam int frac_w = 8;
    // Exact sum or difference, one guard bit on top
    localparam int wide_w = data_w + 1;

    //--------------------------------------------------
    // Result FIFO
    //--------------------------------------------------
    localparam int fifo_depth = 8;
    // Pointer width, log2 of depth
    localparam int fifo_ptr_w = 3;

    //--------------------------------------------------
    // Saturation limits
    //--------------------------------------------------
    // Largest Q8.8 value, just under +128.0
    localparam logic [data_w-1:0] sat_max = 16'h7FFF;
    // Smallest Q8.8 value, exactly -128.0
    localparam logic [data_w-1:0] sat_min = 16'h8000;

endpackage

// File: fxp_result_fifo.sv
//--------------------------------------------------
// Result FIFO
// Show-ahead circular buffer of wide results; the
// head entry is always visible on rd_data. space
// keeps one slot free for a result still in the
// operand stage register
//--------------------------------------------------
`timescale 1ns/100ps

module fxp_result_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  logic [fxp_pkg::wide_w-1:0]  wr_data,
    input  logic                        rd_en,
    output logic                        rd_valid,
    output logic [fxp_pkg::wide_w-1:0]  rd_data,
    output logic                        space
);

    //--------------------------------------------------
    // Storage and pointers
    //--------------------------------------------------
    logic [fxp_pkg::wide_w-1:0]   mem [fxp_pkg::fifo_depth];
    // Next slot to write
    logic [fxp_pkg::fifo_ptr_w-1:0] wr_ptr;
    // Head slot
    logic [fxp_pkg::fifo_ptr_w-1:0] rd_ptr;
    // Occupancy from 0 up to fifo_depth
    logic [fxp_pkg::fifo_ptr_w:0]   count;

    // Data store
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Idle or write and pop together
                default: count <= count;
            endcase
        end
    end

    //--------------------------------------------------
    // Status and head
    //--------------------------------------------------
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    // Below depth minus one so one more in flight still fits
    assign space = (count < (fxp_pkg::fifo_ptr_w + 1)'(fxp_pkg::fifo_depth - 1));

endmodule

// File: fxp_saturate_stage.sv
//--------------------------------------------------
// Saturate stage
// Pops wide results from the FIFO, clamps them to
// Q8.8 and holds each one on the output until the
// sink takes it with out_ready
//--------------------------------------------------
`timescale 1ns/100ps

module fxp_saturate_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_valid,
    input  logic [fxp_pkg::wide_w-1:0]  rd_data,
    input  logic                        out_ready,
    output logic                        rd_en,
    output logic                        out_valid,
    output logic [fxp_pkg::data_w-1:0]  result,
    output logic                        saturated
);

    // Guard bit and Q8.8 sign bit disagree
    logic                       overflow;
    // Clamped value for the head entry
    logic [fxp_pkg::data_w-1:0] clamped;

    //--------------------------------------------------
    // Clamp
    //--------------------------------------------------
    assign overflow = rd_data[fxp_pkg::wide_w-1] ^ rd_data[fxp_pkg::data_w-1];

    // Guard bit gives the true sign of the wide value
    assign clamped = !overflow                     ? rd_data[fxp_pkg::data_w-1:0] :
                     rd_data[fxp_pkg::wide_w-1]    ? fxp_pkg::sat_min :
                                                     fxp_pkg::sat_max;

    //--------------------------------------------------
    // Output register
    //--------------------------------------------------
    // Pop when the output is empty or emptying this cycle
    assign rd_en = rd_valid && (!out_valid || out_ready);

    // Valid flag, held until out_ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (rd_en) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only changes on a pop
    always_ff @(posedge clk) begin
        if (rd_en) begin
            result    <= clamped;
            saturated <= overflow;
        end
    end

endmodule

// File: fxp_subtract.sv
//--------------------------------------------------
// Signed subtractor
// Exact two's-complement a - b, one bit wider than
// the operands, formed on the carry-chain adder
//--------------------------------------------------
`timescale 1ns/100ps

module fxp_subtract #(
    // Operand width in bits
    parameter int n = 16
) (
    input  logic [n-1:0] a,
    input  logic [n-1:0] b,
    output logic [n:0]   diff
);

    // Sign-extended operands
    logic [n:0] a_ext;
    logic [n:0] b_ext;
    // Ones' complement of the subtrahend
    logic [n:0] b_inv;

    // Extend by the top bit so the result can't overflow
    assign a_ext = {a[n-1], a};
    assign b_ext = {b[n-1], b};

    // Invert every bit, the +1 comes in as carry
    assign b_inv = ~b_ext;

    // a + ~b + 1
    fxp_add #(
        .n        (n + 1)
    ) u_add (
        .a        (a_ext),
        .b        (b_inv),
        .carry_in (1'b1),
        .sum      (diff),
        // Carry out has no meaning for a signed difference
        .carry_out()
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the fixed-point ALU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_fxp_alu \
    -o tb_fxp_alu_sim

./obj_dir/tb_fxp_alu_sim | tee sim.log

# Verdict comes from the log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation run passed"
    exit 0
else
    echo "Simulation run failed"
    exit 1
fi

// File: tb_clock_gen.sv
//--------------------------------------------------
// Testbench clock and reset
// 20 ns clock and rst_n held low for the first 10
// rising edges
//--------------------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 10;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release lines up with a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tb_fxp_alu.sv
//--------------------------------------------------
// Testbench for the fixed-point add/subtract unit
// Replays the case file twice: one operation at a
// time with out_ready high to check latency, then
// as a burst under random output back-pressure
//--------------------------------------------------
`timescale 1ns/100ps

module tb_fxp_alu;

    // Case file layout, five hex words per case
    localparam int          max_cases     = 64;
    localparam int          case_words    = 5;
    // Op column value after the last case
    localparam logic [15:0] end_marker    = 16'hffff;
    // Wait limits in clock cycles
    localparam int          reset_timeout = 50;
    localparam int          out_timeout   = 20;
    localparam int          burst_timeout = 100;
    localparam int          drain_timeout = 400;

    logic        clk;
    logic        rst_n;
    // DUT inputs
    logic        in_valid  = 1'b0;
    logic        op_sub    = 1'b0;
    logic [15:0] a         = 16'h0000;
    logic [15:0] b         = 16'h0000;
    logic        out_ready = 1'b0;
    // DUT outputs
    logic        in_ready;
    logic        out_valid;
    logic [15:0] result;
    logic        saturated;

    // Case words and the queue of outputs still owed
    logic [15:0] case_mem [case_words*max_cases];
    int          n_cases;
    logic [16:0] expected_q [$];
    logic [16:0] exp_word;

    int          checks   = 0;
    int          errors   = 0;
    int          accepted = 0;
    // Back-pressure source
    logic        random_mode = 1'b0;
    logic [31:0] lfsr        = 32'h1331e994;
    logic        lfsr_bit;
    // Monitor state, sampled on the falling edge
    logic        ready_seen        = 1'b0;
    logic        in_ready_low_seen = 1'b0;
    logic        hold_pending      = 1'b0;
    logic [15:0] held_result;
    logic        held_sat;

    tb_clock_gen i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fxp_alu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op_sub    (op_sub),
        .a         (a),
        .b         (b),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .result    (result),
        .saturated (saturated)
    );

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Exact sum or difference, clamped to Q8.8, sat flag on top
    function automatic logic [16:0] clamp_rule(input logic sub, input logic [15:0] x,
                                               input logic [15:0] y);
        int s;
        s = sub ? int'($signed(x)) - int'($signed(y)) : int'($signed(x)) + int'($signed(y));
        if (s > 32767) return {1'b1, fxp_pkg::sat_max};
        if (s < -32768) return {1'b1, fxp_pkg::sat_min};
        return {1'b0, s[15:0]};
    endfunction

    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure: %s", what);
        end
    endtask

    // Read the cases and check each expected value against the rule
    task automatic load_cases();
        logic [16:0] rule;
        $readmemh("fxp_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < max_cases && case_mem[case_words*n_cases] != end_marker) begin
            n_cases++;
        end
        require(n_cases > 0 && n_cases < max_cases,
                "the case file holds no cases or has no end marker");
        for (int i = 0; i < n_cases; i++) begin
            rule = clamp_rule(case_mem[case_words*i][0], case_mem[case_words*i+1],
                              case_mem[case_words*i+2]);
            compare_field("case file result", case_mem[case_words*i+3], rule[15:0]);
            compare_field("case file saturated", case_mem[case_words*i+4], {15'b0, rule[16]});
        end
    endtask

    // Drive one operation and queue its expected output
    task automatic present_case(input int i);
        in_valid <= 1'b1;
        op_sub   <= case_mem[case_words*i][0];
        a        <= case_mem[case_words*i+1];
        b        <= case_mem[case_words*i+2];
        expected_q.push_back({case_mem[case_words*i+4][0], case_mem[case_words*i+3]});
    endtask

    // Queue empty and output register free
    task automatic wait_drained();
        int n;
        n = 0;
        while (!(expected_q.size() == 0 && !out_valid) && n < drain_timeout) begin
            @(negedge clk);
            n++;
        end
        require(n < drain_timeout, "the DUT did not deliver all pending results");
    endtask

    // One operation into an idle DUT, out_ready high
    task automatic run_single(input int i);
        int  n;
        logic seen;
        @(posedge clk);
        present_case(i);
        n    = 0;
        seen = 1'b0;
        while (!seen && n < out_timeout) begin
            @(negedge clk);
            n++;
            seen = out_valid;
            if (!seen) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        require(seen, "out_valid did not rise after a single operation");
        // First negedge precedes the sampling edge
        compare_field("out_valid latency", 16'(n - 2), 16'd2);
        wait_drained();
    endtask

    // Every case back to back while in_ready allows
    task automatic run_burst();
        int         idx;
        int         idle;
        logic [1:0] recent;
        logic       go;
        idx    = 0;
        idle   = 0;
        recent = 2'b00;
        while (idx < n_cases && idle < burst_timeout) begin
            @(posedge clk);
            // A strobe from two edges back can still land in the FIFO now
            go = ready_seen && !recent[1];
            if (go) begin
                present_case(idx);
                idx++;
                idle = 0;
            end else begin
                in_valid <= 1'b0;
                idle++;
            end
            recent = {recent[0], go};
        end
        @(posedge clk);
        in_valid <= 1'b0;
        require(idx == n_cases, "in_ready stayed low and the burst could not be sent");
    endtask

    //--------------------------------------------------
    // Output back-pressure
    //--------------------------------------------------
    // Two LFSR bits per cycle, ready about one cycle in four
    always @(posedge clk) begin
        if (!rst_n) begin
            out_ready <= 1'b0;
        end else if (random_mode) begin
            lfsr      = lfsr_step(lfsr);
            lfsr_bit  = lfsr[0];
            lfsr      = lfsr_step(lfsr);
            out_ready <= lfsr_bit & lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    //--------------------------------------------------
    // Monitor
    //--------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid && !in_ready) begin
                require(1'b0, "in_valid was high while in_ready was low");
            end
            // Stalled output must not move
            if (hold_pending) begin
                compare_field("out_valid", {15'b0, out_valid}, 16'h0001);
                compare_field("result", result, held_result);
                compare_field("saturated", {15'b0, saturated}, {15'b0, held_sat});
            end
            hold_pending = out_valid && !out_ready;
            held_result  = result;
            held_sat     = saturated;
            // Accepted on the coming rising edge
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    require(1'b0, "an output was accepted with no case pending");
                end else begin
                    exp_word = expected_q.pop_front();
                    compare_field("result", result, exp_word[15:0]);
                    compare_field("saturated", {15'b0, saturated}, {15'b0, exp_word[16]});
                end
                accepted++;
            end
            if (!in_ready) begin
                in_ready_low_seen = 1'b1;
            end
            ready_seen = in_ready;
        end
    end

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin
        int n;
        load_cases();
        n = 0;
        while (!rst_n && n < reset_timeout) begin
            @(negedge clk);
            n++;
        end
        require(rst_n, "reset was never released");
        @(negedge clk);
        compare_field("out_valid", {15'b0, out_valid}, 16'h0000);
        compare_field("in_ready", {15'b0, in_ready}, 16'h0001);

        // Latency and values, one at a time
        for (int i = 0; i < n_cases; i++) begin
            run_single(i);
        end

        // Burst under back-pressure
        @(negedge clk);
        random_mode = 1'b1;
        run_burst();
        wait_drained();
        random_mode = 1'b0;
        require(in_ready_low_seen, "in_ready never fell while the queue filled");
        require(accepted == 2 * n_cases, "the number of accepted outputs is wrong");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
